// File: src/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// buffer entries, indexed by rename tag
// tag 0 marks a ready operand, so entry 0 stays unused
`define LSU_ENTRIES 8

// rename tag width, wide enough to index every entry
`define LSU_TAG_W 3

// RV32 data and address width
`define LSU_XLEN 32

// data memory depth in 32-bit words
`define LSU_MEM_WORDS 256

// request cycle to done cycle
// the counter in data_mem expects at least 2
`define LSU_MEM_LAT 2

`endif

// File: src/lsu_pkg.sv
package lsu_pkg;

    // load/store ops as sent by the dispatcher
    // bit 3 set for stores
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,
        OP_LHU  = 4'd5,
        OP_SB   = 4'd8,
        OP_SH   = 4'd9,
        OP_SW   = 4'd10
    } mem_op_e;

    // access width on the memory port
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    // one memory word, little endian
    // b[0] is the byte at the word address, h[1] the upper half
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage

// File: src/load_store_buffer.sv
`include "lsu_cfg.svh"

module load_store_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  dispatch_valid,
    input  lsu_pkg::mem_op_e      dispatch_op,
    input  logic [`LSU_TAG_W-1:0] dispatch_tag,
    input  logic [`LSU_XLEN-1:0]  dispatch_imm,
    input  logic [`LSU_TAG_W-1:0] rs1_tag,
    input  logic [`LSU_XLEN-1:0]  rs1_data,
    input  logic [`LSU_TAG_W-1:0] rs2_tag,
    input  logic [`LSU_XLEN-1:0]  rs2_data,
    input  logic                  cdb_valid,
    input  logic [`LSU_TAG_W-1:0] cdb_tag,
    input  logic [`LSU_XLEN-1:0]  cdb_data,
    input  logic                  commit_valid,
    input  logic [`LSU_TAG_W-1:0] commit_tag,
    output logic                  full,
    output logic                  mem_req,
    output logic                  mem_store,
    output logic [`LSU_TAG_W-1:0] mem_tag,
    output lsu_pkg::mem_size_e    mem_size,
    output logic [`LSU_XLEN-1:0]  mem_addr,
    output logic [`LSU_XLEN-1:0]  mem_wdata,
    output logic                  mem_unsigned,
    input  logic                  mem_busy,
    input  logic                  mem_done,
    input  logic [`LSU_TAG_W-1:0] mem_done_tag,
    input  logic [`LSU_XLEN-1:0]  mem_rdata,
    output logic                  result_valid,
    output logic [`LSU_TAG_W-1:0] result_tag,
    output logic [`LSU_XLEN-1:0]  result_data
);
    import lsu_pkg::*;

    localparam int ENT = `LSU_ENTRIES;
    localparam int TW  = `LSU_TAG_W;
    localparam int XL  = `LSU_XLEN;

    logic [ENT-1:0] occ;
    logic [ENT-1:0] rdy1;
    logic [ENT-1:0] rdy2;
    logic [ENT-1:0] committed;
    logic [ENT-1:0] issued;

    mem_op_e        op_q  [ENT];
    logic [XL-1:0]  imm_q [ENT];
    logic [TW-1:0]  t1_q  [ENT];
    logic [TW-1:0]  t2_q  [ENT];
    logic [XL-1:0]  d1_q  [ENT];
    logic [XL-1:0]  d2_q  [ENT];

    logic [ENT-1:0] st_cand;
    logic [ENT-1:0] ld_cand;
    logic           st_found;
    logic           ld_found;
    logic [TW-1:0]  st_idx;
    logic [TW-1:0]  ld_idx;
    logic [TW-1:0]  sel_idx;
    logic           can_issue;
    logic           do_issue;
    logic           disp_ok;
    logic           d1_rdy;
    logic           d2_rdy;
    logic [XL-1:0]  d1_in;
    logic [XL-1:0]  d2_in;

    // two wakeup sources, ALU bus first
    function automatic logic bus_hit(input logic [TW-1:0] t);
        return (cdb_valid && cdb_tag == t) || (result_valid && result_tag == t);
    endfunction

    function automatic logic [XL-1:0] bus_data(input logic [TW-1:0] t);
        return (cdb_valid && cdb_tag == t) ? cdb_data : result_data;
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic mem_size_e op_size(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return SIZE_B;
            OP_LH, OP_LHU, OP_SH: return SIZE_H;
            default:              return SIZE_W;
        endcase
    endfunction

    assign full    = &occ[ENT-1:1];
    assign disp_ok = dispatch_valid && !full && dispatch_op != OP_NONE && dispatch_tag != '0;

    // operands at dispatch, catching a broadcast in the same cycle
    always_comb begin
        d1_rdy = (rs1_tag == '0) || bus_hit(rs1_tag);
        d2_rdy = (rs2_tag == '0) || bus_hit(rs2_tag);
        d1_in  = (rs1_tag == '0) ? rs1_data : bus_data(rs1_tag);
        d2_in  = (rs2_tag == '0) ? rs2_data : bus_data(rs2_tag);
    end

    // committed stores beat loads, lowest tag first in each class
    always_comb begin
        st_cand = '0;
        ld_cand = '0;
        st_idx  = '0;
        ld_idx  = '0;
        for (int i = 1; i < ENT; i++) begin
            st_cand[i] = occ[i] && is_store(op_q[i]) && committed[i] && rdy1[i] && rdy2[i];
            ld_cand[i] = occ[i] && !is_store(op_q[i]) && !issued[i] && rdy1[i];
        end
        for (int i = ENT - 1; i >= 1; i--) begin
            if (st_cand[i])
                st_idx = TW'(i);
            if (ld_cand[i])
                ld_idx = TW'(i);
        end
        st_found = |st_cand;
        ld_found = |ld_cand;
    end

    // memory sees busy only a cycle after the request
    assign can_issue = !mem_busy && !mem_req;
    assign do_issue  = can_issue && (st_found || ld_found);
    assign sel_idx   = st_found ? st_idx : ld_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ          <= '0;
            rdy1         <= '0;
            rdy2         <= '0;
            committed    <= '0;
            issued       <= '0;
            mem_req      <= 1'b0;
            result_valid <= 1'b0;
        end else if (flush) begin
            occ          <= '0;
            rdy1         <= '0;
            rdy2         <= '0;
            committed    <= '0;
            issued       <= '0;
            mem_req      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            for (int i = 1; i < ENT; i++) begin
                if (occ[i] && !rdy1[i] && bus_hit(t1_q[i]))
                    rdy1[i] <= 1'b1;
                if (occ[i] && !rdy2[i] && bus_hit(t2_q[i]))
                    rdy2[i] <= 1'b1;
            end
            // held until the store's operands and the memory allow it
            if (commit_valid && occ[commit_tag])
                committed[commit_tag] <= 1'b1;
            mem_req <= do_issue;
            if (do_issue) begin
                if (st_found)
                    occ[sel_idx] <= 1'b0;
                else
                    issued[sel_idx] <= 1'b1;
            end
            result_valid <= mem_done;
            if (mem_done)
                occ[mem_done_tag] <= 1'b0;
            if (disp_ok) begin
                occ[dispatch_tag]       <= 1'b1;
                rdy1[dispatch_tag]      <= d1_rdy;
                rdy2[dispatch_tag]      <= d2_rdy;
                committed[dispatch_tag] <= 1'b0;
                issued[dispatch_tag]    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i < ENT; i++) begin
            if (occ[i] && !rdy1[i] && bus_hit(t1_q[i]))
                d1_q[i] <= bus_data(t1_q[i]);
            if (occ[i] && !rdy2[i] && bus_hit(t2_q[i]))
                d2_q[i] <= bus_data(t2_q[i]);
        end
        if (do_issue) begin
            mem_store    <= st_found;
            mem_tag      <= sel_idx;
            mem_size     <= op_size(op_q[sel_idx]);
            mem_addr     <= d1_q[sel_idx] + imm_q[sel_idx];
            mem_wdata    <= d2_q[sel_idx];
            mem_unsigned <= op_q[sel_idx] inside {OP_LBU, OP_LHU};
        end
        if (mem_done) begin
            result_tag  <= mem_done_tag;
            result_data <= mem_rdata;
        end
        if (disp_ok) begin
            op_q[dispatch_tag]  <= dispatch_op;
            imm_q[dispatch_tag] <= dispatch_imm;
            t1_q[dispatch_tag]  <= rs1_tag;
            t2_q[dispatch_tag]  <= rs2_tag;
            d1_q[dispatch_tag]  <= d1_in;
            d2_q[dispatch_tag]  <= d2_in;
        end
    end

endmodule

// File: src/data_mem.sv
`include "lsu_cfg.svh"

module data_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  req,
    input  logic                  store,
    input  logic [`LSU_TAG_W-1:0] tag,
    input  lsu_pkg::mem_size_e    size,
    input  logic [`LSU_XLEN-1:0]  addr,
    input  logic [`LSU_XLEN-1:0]  wdata,
    input  logic                  op_unsigned,
    output logic                  busy,
    output logic                  done,
    output logic [`LSU_TAG_W-1:0] done_tag,
    output logic [`LSU_XLEN-1:0]  rdata
);
    import lsu_pkg::*;

    localparam int AW = $clog2(`LSU_MEM_WORDS);
    localparam int CW = $clog2(`LSU_MEM_LAT + 1);
    localparam int XL = `LSU_XLEN;

    mem_word_u     mem [`LSU_MEM_WORDS];
    logic [CW-1:0] cnt;
    logic          st_q;
    mem_size_e     size_q;
    logic [XL-1:0] addr_q;
    logic [XL-1:0] wdata_q;
    logic          uns_q;
    logic          accept;
    logic          fire;
    logic [AW-1:0] widx;
    mem_word_u     cur;
    mem_word_u     wr_word;
    logic [7:0]    bsel;
    logic [15:0]   hsel;
    logic [XL-1:0] ld_val;

    // a flush cancels loads, a committed store still lands
    assign accept = req && !busy && (store || !flush);
    assign fire   = busy && cnt == CW'(1);
    assign widx   = addr_q[AW+1:2];
    assign cur    = mem[widx];
    assign bsel   = cur.b[addr_q[1:0]];
    assign hsel   = cur.h[addr_q[1]];

    always_comb begin
        case (size_q)
            SIZE_B:  ld_val = {{(XL-8){!uns_q && bsel[7]}}, bsel};
            SIZE_H:  ld_val = {{(XL-16){!uns_q && hsel[15]}}, hsel};
            default: ld_val = cur;
        endcase
    end

    // read-modify-write of the addressed lane
    always_comb begin
        wr_word = cur;
        case (size_q)
            SIZE_B:  wr_word.b[addr_q[1:0]] = wdata_q[7:0];
            SIZE_H:  wr_word.h[addr_q[1]] = wdata_q[15:0];
            default: wr_word = wdata_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= fire && !st_q && !flush;
            if (busy) begin
                if (fire || (flush && !st_q))
                    busy <= 1'b0;
                else
                    cnt <= cnt - 1'b1;
            end else if (accept) begin
                busy <= 1'b1;
                cnt  <= CW'(`LSU_MEM_LAT - 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            st_q     <= store;
            done_tag <= tag;
            size_q   <= size;
            addr_q   <= addr;
            wdata_q  <= wdata;
            uns_q    <= op_unsigned;
        end
        if (fire && !st_q)
            rdata <= ld_val;
        if (fire && st_q)
            mem[widx] <= wr_word;
    end

endmodule

// File: src/lsu_top.sv
`include "lsu_cfg.svh"

module lsu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  dispatch_valid,
    input  lsu_pkg::mem_op_e      dispatch_op,
    input  logic [`LSU_TAG_W-1:0] dispatch_tag,
    input  logic [`LSU_XLEN-1:0]  dispatch_imm,
    input  logic [`LSU_TAG_W-1:0] rs1_tag,
    input  logic [`LSU_XLEN-1:0]  rs1_data,
    input  logic [`LSU_TAG_W-1:0] rs2_tag,
    input  logic [`LSU_XLEN-1:0]  rs2_data,
    input  logic                  cdb_valid,
    input  logic [`LSU_TAG_W-1:0] cdb_tag,
    input  logic [`LSU_XLEN-1:0]  cdb_data,
    input  logic                  commit_valid,
    input  logic [`LSU_TAG_W-1:0] commit_tag,
    output logic                  full,
    output logic                  result_valid,
    output logic [`LSU_TAG_W-1:0] result_tag,
    output logic [`LSU_XLEN-1:0]  result_data
);
    import lsu_pkg::*;

    // buffer to memory
    logic                  mem_req;
    logic                  mem_store;
    logic [`LSU_TAG_W-1:0] mem_tag;
    mem_size_e             mem_size;
    logic [`LSU_XLEN-1:0]  mem_addr;
    logic [`LSU_XLEN-1:0]  mem_wdata;
    logic                  mem_unsigned;

    // memory back to buffer
    logic                  mem_busy;
    logic                  mem_done;
    logic [`LSU_TAG_W-1:0] mem_done_tag;
    logic [`LSU_XLEN-1:0]  mem_rdata;

    load_store_buffer u_lsb (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tag   (dispatch_tag),
        .dispatch_imm   (dispatch_imm),
        .rs1_tag        (rs1_tag),
        .rs1_data       (rs1_data),
        .rs2_tag        (rs2_tag),
        .rs2_data       (rs2_data),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .full           (full),
        .mem_req        (mem_req),
        .mem_store      (mem_store),
        .mem_tag        (mem_tag),
        .mem_size       (mem_size),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_unsigned   (mem_unsigned),
        .mem_busy       (mem_busy),
        .mem_done       (mem_done),
        .mem_done_tag   (mem_done_tag),
        .mem_rdata      (mem_rdata),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_data    (result_data)
    );

    data_mem u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .req         (mem_req),
        .store       (mem_store),
        .tag         (mem_tag),
        .size        (mem_size),
        .addr        (mem_addr),
        .wdata       (mem_wdata),
        .op_unsigned (mem_unsigned),
        .busy        (mem_busy),
        .done        (mem_done),
        .done_tag    (mem_done_tag),
        .rdata       (mem_rdata)
    );

endmodule

// File: dv/lsu_tb.sv
`include "lsu_cfg.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int TW        = `LSU_TAG_W;
    localparam int XL        = `LSU_XLEN;
    localparam int MEM_BYTES = 4 * `LSU_MEM_WORDS;
    localparam int TIMEOUT   = 100;

    logic          clk;
    logic          rst_n;
    logic          flush;
    logic          dispatch_valid;
    mem_op_e       dispatch_op;
    logic [TW-1:0] dispatch_tag;
    logic [XL-1:0] dispatch_imm;
    logic [TW-1:0] rs1_tag;
    logic [XL-1:0] rs1_data;
    logic [TW-1:0] rs2_tag;
    logic [XL-1:0] rs2_data;
    logic          cdb_valid;
    logic [TW-1:0] cdb_tag;
    logic [XL-1:0] cdb_data;
    logic          commit_valid;
    logic [TW-1:0] commit_tag;
    logic          full;
    logic          result_valid;
    logic [TW-1:0] result_tag;
    logic [XL-1:0] result_data;

    // byte copy of the data memory, written at commit
    logic [7:0]    ref_mem [MEM_BYTES];
    // outstanding loads by tag
    logic          exp_valid [`LSU_ENTRIES];
    logic [XL-1:0] exp_data  [`LSU_ENTRIES];
    string         test_name;
    int            seed = 22152;

    lsu_top u_dut (.*);

    always #4 clk = ~clk;

    function automatic logic [XL-1:0] ref_load(input mem_op_e op, input logic [XL-1:0] addr);
        int            a;
        logic [XL-1:0] w;
        logic [XL-1:0] sh;
        a  = int'(addr % MEM_BYTES) & ~3;
        w  = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        sh = w >> (8 * addr[1:0]);
        case (op)
            OP_LB:   return {{24{sh[7]}}, sh[7:0]};
            OP_LBU:  return {24'h0, sh[7:0]};
            OP_LH:   return {{16{sh[15]}}, sh[15:0]};
            OP_LHU:  return {16'h0, sh[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic void ref_store(input mem_op_e op, input logic [XL-1:0] addr,
                                      input logic [XL-1:0] data);
        int a;
        a = int'(addr % MEM_BYTES);
        ref_mem[a] = data[7:0];
        if (op != OP_SB)
            ref_mem[a+1] = data[15:8];
        if (op == OP_SW) begin
            ref_mem[a+2] = data[23:16];
            ref_mem[a+3] = data[31:24];
        end
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [XL-1:0] expected,
                               input logic [XL-1:0] actual);
        if (actual !== expected)
            stop_run($sformatf("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual));
    endtask

    // called on a falling edge, returns on the next one
    task automatic dispatch(input mem_op_e op, input logic [TW-1:0] tag,
                            input logic [XL-1:0] imm,
                            input logic [TW-1:0] t1, input logic [XL-1:0] d1,
                            input logic [TW-1:0] t2, input logic [XL-1:0] d2);
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_tag   = tag;
        dispatch_imm   = imm;
        rs1_tag        = t1;
        rs1_data       = d1;
        rs2_tag        = t2;
        rs2_data       = d2;
        @(negedge clk);
        dispatch_valid = 1'b0;
        dispatch_op    = OP_NONE;
    endtask

    function automatic void expect_load(input logic [TW-1:0] tag, input mem_op_e op,
                                        input logic [XL-1:0] addr);
        exp_valid[tag] = 1'b1;
        exp_data[tag]  = ref_load(op, addr);
    endfunction

    // base and immediate split so that address is base + 4
    task automatic issue_store(input mem_op_e op, input logic [TW-1:0] tag,
                               input logic [XL-1:0] addr, input logic [XL-1:0] data);
        dispatch(op, tag, 32'h4, 3'd0, addr - 32'h4, 3'd0, data);
    endtask

    // negative immediate
    task automatic issue_load(input mem_op_e op, input logic [TW-1:0] tag,
                              input logic [XL-1:0] addr);
        expect_load(tag, op, addr);
        dispatch(op, tag, 32'hffff_fffc, 3'd0, addr + 32'h4, 3'd0, 32'h0);
    endtask

    task automatic commit(input logic [TW-1:0] tag, input mem_op_e op,
                          input logic [XL-1:0] addr, input logic [XL-1:0] data);
        ref_store(op, addr, data);
        commit_valid = 1'b1;
        commit_tag   = tag;
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [TW-1:0] tag, input logic [XL-1:0] data);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_data  = data;
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    task automatic idle_quiet(input int cycles);
        repeat (cycles) begin
            check_value({test_name, " no result"}, 32'h0, XL'(result_valid));
            @(negedge clk);
        end
    endtask

    task automatic wait_result(input logic [TW-1:0] tag);
        int n = 0;
        @(posedge clk);
        while (exp_valid[tag]) begin
            if (n >= TIMEOUT)
                stop_run($sformatf("timed out waiting for the load with tag %0d", tag));
            else begin
                n++;
                @(posedge clk);
            end
        end
        @(negedge clk);
    endtask

    // result bus checker
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (!exp_valid[result_tag])
                stop_run($sformatf("result for tag %0d with no load outstanding", result_tag));
            else begin
                check_value($sformatf("%s tag %0d", test_name, result_tag),
                            exp_data[result_tag], result_data);
                exp_valid[result_tag] = 1'b0;
            end
        end
    end

    initial begin
        logic [XL-1:0] word;
        logic [XL-1:0] base;
        int            ob;
        int            oh;
        clk            = 1'b0;
        rst_n          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_NONE;
        dispatch_tag   = '0;
        dispatch_imm   = '0;
        rs1_tag        = '0;
        rs1_data       = '0;
        rs2_tag        = '0;
        rs2_data       = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_data       = '0;
        commit_valid   = 1'b0;
        commit_tag     = '0;
        for (int i = 0; i < `LSU_ENTRIES; i++)
            exp_valid[i] = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset";
        check_value({test_name, " full"}, 32'h0, XL'(full));
        idle_quiet(20);

        test_name = "word";
        word = $random(seed);
        issue_store(OP_SW, 3'd1, 32'h40, word);
        commit(3'd1, OP_SW, 32'h40, word);
        issue_load(OP_LW, 3'd2, 32'h40);
        wait_result(3'd2);

        // stores force the sign bits so LB and LH extend negative
        test_name = "sizes";
        base = 32'h100;
        word = $random(seed);
        issue_store(OP_SW, 3'd1, base, word);
        commit(3'd1, OP_SW, base, word);
        ob   = $unsigned($random(seed)) % 4;
        word = $random(seed) | 32'h80;
        issue_store(OP_SB, 3'd2, base + ob, word);
        commit(3'd2, OP_SB, base + ob, word);
        oh   = 2 * ($unsigned($random(seed)) % 2);
        word = $random(seed) | 32'h8080;
        issue_store(OP_SH, 3'd3, base + oh, word);
        commit(3'd3, OP_SH, base + oh, word);
        issue_load(OP_LB, 3'd4, base + ob);
        issue_load(OP_LBU, 3'd5, base + ob);
        issue_load(OP_LH, 3'd6, base + oh);
        issue_load(OP_LHU, 3'd7, base + oh);
        for (int t = 4; t < `LSU_ENTRIES; t++)
            wait_result(TW'(t));
        issue_load(OP_LW, 3'd1, base);
        wait_result(3'd1);

        test_name = "wakeup";
        expect_load(3'd1, OP_LW, 32'h40);
        dispatch(OP_LW, 3'd1, 32'h0, 3'd5, 32'h0, 3'd0, 32'h0);
        word = $random(seed);
        dispatch(OP_SW, 3'd2, 32'h8, 3'd6, 32'h0, 3'd7, 32'h0);
        commit(3'd2, OP_SW, 32'h80, word);
        idle_quiet(12);
        broadcast(3'd6, 32'h78);
        broadcast(3'd7, word);
        broadcast(3'd5, 32'h40);
        wait_result(3'd1);
        issue_load(OP_LW, 3'd3, 32'h80);
        wait_result(3'd3);

        // second load takes its base from the first load's result
        test_name = "chain";
        issue_store(OP_SW, 3'd1, 32'h200, 32'h300);
        commit(3'd1, OP_SW, 32'h200, 32'h300);
        word = $random(seed);
        issue_store(OP_SW, 3'd2, 32'h308, word);
        commit(3'd2, OP_SW, 32'h308, word);
        issue_load(OP_LW, 3'd3, 32'h200);
        expect_load(3'd4, OP_LW, ref_load(OP_LW, 32'h200) + 32'h8);
        dispatch(OP_LW, 3'd4, 32'h8, 3'd3, 32'h0, 3'd0, 32'h0);
        wait_result(3'd3);
        wait_result(3'd4);

        // tag 7 never broadcast, so every base stays pending
        test_name = "full_flush";
        for (int t = 1; t < `LSU_ENTRIES; t++) begin
            check_value({test_name, " full early"}, 32'h0, XL'(full));
            dispatch(OP_LW, TW'(t), 32'h0, 3'd7, 32'h0, 3'd0, 32'h0);
        end
        check_value({test_name, " full"}, 32'h1, XL'(full));
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_value({test_name, " full after flush"}, 32'h0, XL'(full));
        idle_quiet(10);
        issue_load(OP_LW, 3'd2, 32'h308);
        wait_result(3'd2);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/lsu_pkg.sv
src/load_store_buffer.sv
src/data_mem.sv
src/lsu_top.sv
dv/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator, pass decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module lsu_tb -f all.f -o lsu_sim \
    && ./obj_dir/lsu_sim > sim.log 2>&1
grep -qx '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
